// File: ramPkg.sv
package ramPkg;

//----------------------------------------------------------------------
// CSR window, byte offsets of 32 bit words
//----------------------------------------------------------------------
localparam int cCsrCtrl   = 'h00;	// Control, bit 0 enable
localparam int cCsrStat   = 'h04;	// Status, read only
localparam int cCsrWrCnt  = 'h08;	// Finished writes
localparam int cCsrRdCnt  = 'h0c;	// Finished reads
localparam int cCsrLastRd = 'h10;	// Most recent SRAM read data

// Status word layout
localparam int cStatBusyBit = 0;	// Sequencer not idle

//----------------------------------------------------------------------
// Pin sequencer
//----------------------------------------------------------------------
// Write path  Idle > WrSetup > WrPulse  > Release > Idle
// Read path   Idle > RdSetup > RdSample > Release > Idle
typedef enum logic [2:0] {
	Idle,		// Waiting for a queue entry
	WrSetup,	// Address and CE valid
	WrPulse,	// WE low, data on the pins
	RdSetup,	// Address, CE and OE valid
	RdSample,	// Access time, data captured at the end
	Release		// Pins back to inactive
} seqStateT;

// Clocks one SRAM access keeps the sequencer busy
localparam int cSeqCycles = 3;

endpackage

// File: ramStatIf.sv
// Status path between the SRAM unit and the CSR block
interface ramStatIf #(
	parameter int pRamDqWidth = 8
);
	logic [pRamDqWidth-1:0]	rdData;		// Last data read from the SRAM
	logic					rdValid;	// One cycle, rdData just updated
	logic					wrDone;		// One cycle, write finished
	logic					busy;		// Sequencer away from Idle
	logic					enable;		// Control bit, 0 stalls new accesses

	// SRAM unit side
	modport producer (
		output rdData, rdValid, wrDone, busy,
		input  enable
	);

	// CSR side
	modport consumer (
		input  rdData, rdValid, wrDone, busy,
		output enable
	);
endinterface

// File: ramFifo.sv
module ramFifo #(
	parameter type	pPayload		= logic [7:0],
	parameter int	pRamFifoDepth	= 16			// At least 2 entries
)(
	input  logic	iSysClk,
	input  logic	rstN,
	input  logic	push,
	input  pPayload	pushData,
	input  logic	pop,
	output pPayload	popData,	// Head entry, valid while not empty
	output logic	empty,
	output logic	full
);

localparam int cPtrW = $clog2(pRamFifoDepth);
localparam int cLast = pRamFifoDepth - 1;

pPayload			mem [pRamFifoDepth];	// Storage, no reset
logic [cPtrW-1:0]	wrPtr;
logic [cPtrW-1:0]	rdPtr;
logic [cPtrW:0]		count;					// One extra bit for full

//----------------------------------------------------------------------
// Pointers and fill level
//----------------------------------------------------------------------
always_ff @(posedge iSysClk or negedge rstN)
begin
	if (!rstN)
	begin
		wrPtr <= '0;
		rdPtr <= '0;
		count <= '0;
	end
	else
	begin
		if (push)
			wrPtr <= (wrPtr == cPtrW'(cLast)) ? '0 : wrPtr + 1'b1;	// Wrap at depth
		if (pop)
			rdPtr <= (rdPtr == cPtrW'(cLast)) ? '0 : rdPtr + 1'b1;
		case ({push, pop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;		// Both or neither
		endcase
	end
end

always_ff @(posedge iSysClk)
begin
	if (push)
		mem[wrPtr] <= pushData;
end

// Show-ahead head
assign popData = mem[rdPtr];
assign empty   = (count == '0);
assign full    = (count == (cPtrW + 1)'(pRamFifoDepth));

// Producer and consumer both honour the flags
assert property (@(posedge iSysClk) disable iff (!rstN) !(push && full))
	else $error("ramFifo push while full");
assert property (@(posedge iSysClk) disable iff (!rstN) !(pop && empty))
	else $error("ramFifo pop while empty");

endmodule

// File: ramPinSeq.sv
module ramPinSeq
	import ramPkg::*;
#(
	parameter int pRamAdrsWidth	= 19,
	parameter int pRamDqWidth	= 8
)(
	input  logic								iSysClk,
	input  logic								rstN,
	// Write queue head, address above data
	input  logic								wrEmpty,
	input  logic [pRamAdrsWidth+pRamDqWidth-1:0]	wrData,
	output logic								wrPop,
	// Read queue head
	input  logic								rdEmpty,
	input  logic [pRamAdrsWidth-1:0]			rdData,
	output logic								rdPop,
	// SRAM pins, controls active low
	output logic [pRamAdrsWidth-1:0]			memAdrs,
	inout  wire  [pRamDqWidth-1:0]				memDq,
	output logic								memOE,
	output logic								memWE,
	output logic								memCE,
	// Ufi read return
	output logic [pRamDqWidth-1:0]				ufiRd,
	output logic								ufiRdEd,
	ramStatIf.producer							stat
);

seqStateT					state;
logic [pRamAdrsWidth-1:0]	adrsReg;	// Address of the running access
logic [pRamDqWidth-1:0]		dataReg;	// Write data of the running access
logic						curWr;		// Running access is a write
logic						dqDrive;

//----------------------------------------------------------------------
// Arbitration, writes first, nothing new while disabled
//----------------------------------------------------------------------
assign wrPop = (state == Idle) && stat.enable && !wrEmpty;
assign rdPop = (state == Idle) && stat.enable && wrEmpty && !rdEmpty;

always_ff @(posedge iSysClk or negedge rstN)
begin
	if (!rstN)
	begin
		state       <= Idle;
		curWr       <= 1'b0;
		ufiRdEd     <= 1'b0;
		stat.wrDone <= 1'b0;
	end
	else
	begin
		ufiRdEd     <= 1'b0;		// Pulses by default
		stat.wrDone <= 1'b0;
		case (state)
			Idle:
			begin
				if (wrPop)
				begin
					state <= WrSetup;
					curWr <= 1'b1;
				end
				else if (rdPop)
				begin
					state <= RdSetup;
					curWr <= 1'b0;
				end
			end
			WrSetup:  state <= WrPulse;
			WrPulse:
			begin
				state       <= Release;
				stat.wrDone <= 1'b1;	// Seen during Release
			end
			RdSetup:  state <= RdSample;
			RdSample:
			begin
				state   <= Release;
				ufiRdEd <= 1'b1;		// Data captured on this edge
			end
			default:  state <= Idle;	// Release
		endcase
	end
end

// Access payload, loaded from the queue head on the pop
always_ff @(posedge iSysClk)
begin
	if (wrPop)
		{adrsReg, dataReg} <= wrData;
	else if (rdPop)
		adrsReg <= rdData;
	if (state == RdSample)
		ufiRd <= memDq;					// End of the access time
end

//----------------------------------------------------------------------
// Pin decode
//----------------------------------------------------------------------
assign memAdrs = adrsReg;
assign memCE   = !(state inside {WrSetup, WrPulse, RdSetup, RdSample});
assign memWE   = !(state == WrPulse);
assign memOE   = !(state inside {RdSetup, RdSample});
assign dqDrive = (state == WrPulse) || ((state == Release) && curWr);	// Hold after WE
assign memDq   = dqDrive ? dataReg : 'z;

assign stat.rdData  = ufiRd;
assign stat.rdValid = ufiRdEd;
assign stat.busy    = (state != Idle);

// Bus contention on the SRAM side
assert property (@(posedge iSysClk) disable iff (!rstN) !(!memOE && !memWE))
	else $error("memOE and memWE active together");
assert property (@(posedge iSysClk) disable iff (!rstN) !(dqDrive && !memOE))
	else $error("memDq driven while memOE active");
// Every access is exactly cSeqCycles long and returns through Idle
assert property (@(posedge iSysClk) disable iff (!rstN)
	$rose(stat.busy) |-> stat.busy [*cSeqCycles] ##1 !stat.busy)
	else $error("SRAM access length off");

endmodule

// File: ramUnit.sv
module ramUnit #(
	parameter int pBusAdrsBit	= 32,
	parameter int pRamFifoDepth	= 16,
	parameter int pRamAdrsWidth	= 19,
	parameter int pRamDqWidth	= 8
)(
	input  logic	iSysClk,
	input  logic	rstN,
	// Ufi slave
	input  logic [pRamDqWidth-1:0]		ufiWd,
	input  logic [pBusAdrsBit-1:0]		ufiAdrs,
	input  logic						ufiWEd,
	input  logic						ufiREd,
	input  logic						ufiCmd,		// High read, low write
	output logic [pRamDqWidth-1:0]		ufiRd,
	output logic						ufiRdEd,
	output logic						ufiRdy,
	// SRAM pins
	output logic [pRamAdrsWidth-1:0]	memAdrs,
	inout  wire  [pRamDqWidth-1:0]		memDq,
	output logic						memOE,
	output logic						memWE,
	output logic						memCE,
	ramStatIf.producer					stat
);

// Queue entries
typedef struct packed {
	logic [pRamAdrsWidth-1:0]	adrs;
	logic [pRamDqWidth-1:0]		data;
} wrReqT;

typedef struct packed {
	logic [pRamAdrsWidth-1:0]	adrs;
} rdReqT;

wrReqT	wrIn, wrHead;
rdReqT	rdIn, rdHead;
logic	wrPush, wrPop, wrEmpty, wrFull;
logic	rdPush, rdPop, rdEmpty, rdFull;

//----------------------------------------------------------------------
// Strobe split
//----------------------------------------------------------------------
assign ufiRdy = !wrFull && !rdFull;					// Either full blocks both
assign wrPush = ufiWEd && !ufiCmd && ufiRdy;
assign rdPush = ufiREd && ufiCmd && ufiRdy;
assign wrIn   = '{adrs: ufiAdrs[pRamAdrsWidth-1:0], data: ufiWd};	// Upper bits dropped
assign rdIn   = '{adrs: ufiAdrs[pRamAdrsWidth-1:0]};

ramFifo #(.pPayload(wrReqT), .pRamFifoDepth(pRamFifoDepth)) wrFifo (
	.iSysClk(iSysClk), .rstN(rstN),
	.push(wrPush), .pushData(wrIn), .pop(wrPop), .popData(wrHead),
	.empty(wrEmpty), .full(wrFull)
);

ramFifo #(.pPayload(rdReqT), .pRamFifoDepth(pRamFifoDepth)) rdFifo (
	.iSysClk(iSysClk), .rstN(rstN),
	.push(rdPush), .pushData(rdIn), .pop(rdPop), .popData(rdHead),
	.empty(rdEmpty), .full(rdFull)
);

ramPinSeq #(.pRamAdrsWidth(pRamAdrsWidth), .pRamDqWidth(pRamDqWidth)) pinSeq (
	.iSysClk(iSysClk), .rstN(rstN),
	.wrEmpty(wrEmpty), .wrData(wrHead), .wrPop(wrPop),
	.rdEmpty(rdEmpty), .rdData(rdHead), .rdPop(rdPop),
	.memAdrs(memAdrs), .memDq(memDq), .memOE(memOE), .memWE(memWE), .memCE(memCE),
	.ufiRd(ufiRd), .ufiRdEd(ufiRdEd), .stat(stat)
);

endmodule

// File: ramCsr.sv
module ramCsr
	import ramPkg::*;
#(
	parameter int						pBlockAdrsMap	= 8,
	parameter logic [pBlockAdrsMap-1:0]	pAdrsMap		= 'h06,
	parameter int						pBusAdrsBit		= 32,
	parameter int						pCsrAdrsWidth	= 16,
	parameter int						pRamDqWidth		= 8
)(
	input  logic					iSysClk,
	input  logic					rstN,
	// Usi slave
	input  logic [31:0]				usiWd,
	input  logic [pBusAdrsBit-1:0]	usiAdrs,
	input  logic					usiWCke,
	input  logic					usiRCke,
	output logic [31:0]				usiRd,
	output logic					usiREd,
	ramStatIf.consumer				stat
);

logic [pCsrAdrsWidth-1:0]	ofs;
logic						hit;		// Block select matches
logic						known;		// Offset maps to a register
logic						ctrlEnable;
logic [31:0]				wrCnt;
logic [31:0]				rdCnt;
logic [pRamDqWidth-1:0]		lastRd;
logic [31:0]				rdMux;

//----------------------------------------------------------------------
// Address decode
//----------------------------------------------------------------------
assign hit = (usiAdrs[pBusAdrsBit-1 -: pBlockAdrsMap] == pAdrsMap);
assign ofs = usiAdrs[pCsrAdrsWidth-1:0];

always_comb
begin
	known = 1'b1;
	rdMux = '0;
	case (ofs)
		pCsrAdrsWidth'(cCsrCtrl):   rdMux[0] = ctrlEnable;
		pCsrAdrsWidth'(cCsrStat):   rdMux[cStatBusyBit] = stat.busy;
		pCsrAdrsWidth'(cCsrWrCnt):  rdMux = wrCnt;
		pCsrAdrsWidth'(cCsrRdCnt):  rdMux = rdCnt;
		pCsrAdrsWidth'(cCsrLastRd): rdMux = 32'(lastRd);	// Zero extended
		default:                    known = 1'b0;
	endcase
end

// Control, counters and last read
always_ff @(posedge iSysClk or negedge rstN)
begin
	if (!rstN)
	begin
		ctrlEnable <= 1'b1;		// Sequencer runs out of reset
		wrCnt      <= '0;
		rdCnt      <= '0;
		lastRd     <= '0;
		usiREd     <= 1'b0;
	end
	else
	begin
		if (hit && usiWCke && (ofs == pCsrAdrsWidth'(cCsrCtrl)))
			ctrlEnable <= usiWd[0];
		if (stat.wrDone)
			wrCnt <= wrCnt + 1'b1;
		if (stat.rdValid)
		begin
			rdCnt  <= rdCnt + 1'b1;
			lastRd <= stat.rdData;
		end
		usiREd <= hit && usiRCke && known;	// Foreign or unknown stays silent
	end
end

// Read data, one cycle after the request
always_ff @(posedge iSysClk)
begin
	if (hit && usiRCke && known)
		usiRd <= rdMux;
end

assign stat.enable = ctrlEnable;

endmodule

// File: ramBlock.sv
module ramBlock #(
	parameter int						pBlockAdrsMap	= 8,
	parameter logic [pBlockAdrsMap-1:0]	pAdrsMap		= 'h06,
	parameter int						pBusAdrsBit		= 32,
	parameter int						pCsrAdrsWidth	= 16,
	parameter int						pRamFifoDepth	= 16,	// Per request queue
	parameter int						pRamAdrsWidth	= 19,
	parameter int						pRamDqWidth		= 8		// SRAM and Ufi width
)(
	input  logic	iSysClk,
	input  logic	rstN,
	// Ufi slave
	input  logic [pRamDqWidth-1:0]		ufiWd,
	input  logic [pBusAdrsBit-1:0]		ufiAdrs,
	input  logic						ufiWEd,
	input  logic						ufiREd,
	input  logic						ufiCmd,
	output logic [pRamDqWidth-1:0]		ufiRd,
	output logic						ufiRdEd,
	output logic						ufiRdy,
	// Usi slave
	input  logic [31:0]					usiWd,
	input  logic [pBusAdrsBit-1:0]		usiAdrs,
	input  logic						usiWCke,
	input  logic						usiRCke,
	output logic [31:0]					usiRd,
	output logic						usiREd,
	// External SRAM
	output logic [pRamAdrsWidth-1:0]	memAdrs,
	inout  wire  [pRamDqWidth-1:0]		memDq,
	output logic						memOE,
	output logic						memWE,
	output logic						memCE
);

//----------------------------------------------------------------------
// SRAM unit and CSR space
//----------------------------------------------------------------------
ramStatIf #(.pRamDqWidth(pRamDqWidth)) ramStat ();

ramUnit #(
	.pBusAdrsBit	(pBusAdrsBit),
	.pRamFifoDepth	(pRamFifoDepth),
	.pRamAdrsWidth	(pRamAdrsWidth),
	.pRamDqWidth	(pRamDqWidth)
) ramUnitInst (
	.iSysClk(iSysClk), .rstN(rstN),
	.ufiWd(ufiWd), .ufiAdrs(ufiAdrs), .ufiWEd(ufiWEd), .ufiREd(ufiREd), .ufiCmd(ufiCmd),
	.ufiRd(ufiRd), .ufiRdEd(ufiRdEd), .ufiRdy(ufiRdy),
	.memAdrs(memAdrs), .memDq(memDq), .memOE(memOE), .memWE(memWE), .memCE(memCE),
	.stat(ramStat.producer)
);

ramCsr #(
	.pBlockAdrsMap	(pBlockAdrsMap),
	.pAdrsMap		(pAdrsMap),
	.pBusAdrsBit	(pBusAdrsBit),
	.pCsrAdrsWidth	(pCsrAdrsWidth),
	.pRamDqWidth	(pRamDqWidth)
) ramCsrInst (
	.iSysClk(iSysClk), .rstN(rstN),
	.usiWd(usiWd), .usiAdrs(usiAdrs), .usiWCke(usiWCke), .usiRCke(usiRCke),
	.usiRd(usiRd), .usiREd(usiREd),
	.stat(ramStat.consumer)
);

endmodule

// File: sramModel.sv
// Behavioral asynchronous SRAM, controls active low
module sramModel #(
	parameter int pRamAdrsWidth	= 19,
	parameter int pRamDqWidth	= 8
)(
	input  logic [pRamAdrsWidth-1:0]	memAdrs,
	inout  wire  [pRamDqWidth-1:0]		memDq,
	input  logic						memOE,
	input  logic						memWE,
	input  logic						memCE
);

localparam int cWords = 1 << pRamAdrsWidth;

logic [pRamDqWidth-1:0] mem [cWords];

// Power-up contents, every address bit folded in
function automatic logic [pRamDqWidth-1:0] fillValue(input int unsigned a);
	logic [pRamDqWidth-1:0] v;
	v = '0;
	for (int b = 0; b < pRamAdrsWidth; b += pRamDqWidth)
		v = v ^ pRamDqWidth'(a >> b);
	return v ^ pRamDqWidth'('h5a);
endfunction

initial
begin
	for (int a = 0; a < cWords; a++)
		mem[a] = fillValue(a);
end

// Transparent write while CE and WE are both low
always @(memCE or memWE or memAdrs or memDq)
begin
	if (!memCE && !memWE)
		mem[memAdrs] = memDq;
end

assign memDq = (!memCE && !memOE && memWE) ? mem[memAdrs] : 'z;	// Output enable

endmodule

// File: tbRamBlock.sv
module tbRamBlock
	import ramPkg::*;
();

localparam int			cResetCycles	= 8;
localparam int			cStimLen		= 42;
localparam int			cCycleLimit		= cStimLen * (cSeqCycles + 4) * 2 + cResetCycles;
localparam logic [31:0]	cBase			= 32'h0600_0000;	// Block select 0x06
localparam logic [31:0]	cFgn			= 32'h0700_0000;	// Some other block
localparam logic [31:0]	cSeed			= 32'h87409bf5;

typedef enum logic [3:0] {
	OpUfiWr, OpUfiRd,		// Ufi strobes with data from the shadow array
	OpUsiWr, OpUsiRd,		// Usi access inside the block
	OpFgnWr, OpFgnRd,		// Usi access that must stay silent
	OpDrain, OpCounts,
	OpStall					// Data field holds the watch length
} opT;

typedef struct {
	opT				op;
	logic [31:0]	adrs;
	logic [31:0]	data;
	logic [31:0]	expected;
} stimT;

logic			iSysClk;
logic			rstN;
logic [7:0]		ufiWd;
logic [31:0]	ufiAdrs;
logic			ufiWEd, ufiREd, ufiCmd;
logic [7:0]		ufiRd;
logic			ufiRdEd, ufiRdy;
logic [31:0]	usiWd, usiAdrs, usiRd;
logic			usiWCke, usiRCke, usiREd;
logic [18:0]	memAdrs;
wire  [7:0]		memDq;
logic			memOE, memWE, memCE;

stimT			stim [cStimLen];
logic [7:0]		shadow [256];		// Expected SRAM contents by low address byte
logic [7:0]		rdExpect [$];		// Outstanding reads in request order
logic [7:0]		expData;
logic [7:0]		lastRead = '0;
int				wrIssued = 0;
int				rdIssued = 0;
int				cycleCount = 0;

ramBlock #(
	.pBlockAdrsMap(8), .pAdrsMap(8'h06), .pBusAdrsBit(32), .pCsrAdrsWidth(16),
	.pRamFifoDepth(4), .pRamAdrsWidth(19), .pRamDqWidth(8)	// Shallow queues for early back-pressure
) DUT (
	.iSysClk(iSysClk), .rstN(rstN),
	.ufiWd(ufiWd), .ufiAdrs(ufiAdrs), .ufiWEd(ufiWEd), .ufiREd(ufiREd), .ufiCmd(ufiCmd),
	.ufiRd(ufiRd), .ufiRdEd(ufiRdEd), .ufiRdy(ufiRdy),
	.usiWd(usiWd), .usiAdrs(usiAdrs), .usiWCke(usiWCke), .usiRCke(usiRCke),
	.usiRd(usiRd), .usiREd(usiREd),
	.memAdrs(memAdrs), .memDq(memDq), .memOE(memOE), .memWE(memWE), .memCE(memCE)
);

sramModel #(.pRamAdrsWidth(19), .pRamDqWidth(8)) sram (
	.memAdrs(memAdrs), .memDq(memDq), .memOE(memOE), .memWE(memWE), .memCE(memCE)
);

always #50 iSysClk = ~iSysClk;

//----------------------------------------------------------------------
// Helpers enter and leave on a falling edge
//----------------------------------------------------------------------
task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
	if (actual !== expected)
	begin
		$display("CHECK FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
			$time, what, actual, expected);
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at the first mismatch");
	end
endtask

task automatic ufiIssue(input logic isRead, input logic [31:0] adrs);
	while (!ufiRdy)					// Hold off under back-pressure
		@(negedge iSysClk);
	ufiAdrs = adrs;
	ufiCmd  = isRead;
	ufiWd   = shadow[adrs[7:0]];
	ufiWEd  = !isRead;
	ufiREd  = isRead;
	if (isRead)
	begin
		rdExpect.push_back(shadow[adrs[7:0]]);
		rdIssued++;
	end
	else
		wrIssued++;
	@(negedge iSysClk);
	ufiWEd = 1'b0;					// Next call may raise it again at once
	ufiREd = 1'b0;
endtask

task automatic usiWrite(input logic [31:0] adrs, input logic [31:0] data);
	usiAdrs = adrs;
	usiWd   = data;
	usiWCke = 1'b1;
	@(negedge iSysClk);
	usiWCke = 1'b0;
endtask

task automatic usiRead(input logic [31:0] adrs, output logic [31:0] data,
		input logic expectREd);
	checkEq(usiREd, 1'b0, "usiREd low before request");
	usiAdrs = adrs;
	usiRCke = 1'b1;
	@(negedge iSysClk);
	usiRCke = 1'b0;
	checkEq(usiREd, expectREd, "usiREd one cycle after usiRCke");
	data = usiRd;
	@(negedge iSysClk);
	checkEq(usiREd, 1'b0, "usiREd single pulse");
endtask

// Writes run ahead of the reads queued after them
task automatic drainQueues();
	while (rdExpect.size() != 0)
		@(negedge iSysClk);
endtask

task automatic checkCounts();
	logic [31:0] v;
	usiRead(cBase + cCsrWrCnt, v, 1'b1);
	checkEq(v, wrIssued, "write count register");
	usiRead(cBase + cCsrRdCnt, v, 1'b1);
	checkEq(v, rdIssued, "read count register");
	usiRead(cBase + cCsrLastRd, v, 1'b1);
	checkEq(v, 32'(lastRead), "last read register");
endtask

// Read return monitor sampled mid-cycle
always @(negedge iSysClk)
begin
	if (rstN && ufiRdEd)
	begin
		checkEq(32'(rdExpect.size() > 0), 1, "ufiRdEd with a read outstanding");
		expData = rdExpect.pop_front();
		checkEq(ufiRd, expData, "ufiRd data in request order");
		lastRead = expData;
	end
end

// Watchdog
always @(posedge iSysClk)
begin
	cycleCount <= cycleCount + 1;
	if (cycleCount >= cCycleLimit)
	begin
		$display("Timeout: the run did not finish within %0d clock cycles", cCycleLimit);
		$display("Simulation finished: FAIL");
		$fatal(1, "Run stopped by the watchdog");
	end
end

//----------------------------------------------------------------------
// Main sequence
//----------------------------------------------------------------------
initial
begin
	logic [31:0] rdVal;
	iSysClk = 1'b0;
	rstN    = 1'b0;
	ufiWd   = '0;
	ufiAdrs = '0;
	ufiWEd  = 1'b0;
	ufiREd  = 1'b0;
	ufiCmd  = 1'b0;
	usiWd   = '0;
	usiAdrs = '0;
	usiWCke = 1'b0;
	usiRCke = 1'b0;
	void'($urandom(cSeed));
	foreach (shadow[k])
		shadow[k] = 8'($urandom());
	stim = '{
		'{OpUsiRd, cBase + cCsrWrCnt, 0, 0}, '{OpUsiRd, cBase + cCsrRdCnt, 0, 0},
		'{OpUsiRd, cBase + cCsrCtrl, 0, 1},
		'{OpUfiWr, 32'h0000_0000, 0, 0}, '{OpUfiWr, 32'h0000_0013, 0, 0},
		'{OpUfiWr, 32'h0000_7fa5, 0, 0}, '{OpUfiWr, 32'hfff8_0021, 0, 0},	// Upper bits dropped
		'{OpUfiRd, 32'h0000_0000, 0, 0}, '{OpUfiRd, 32'h0000_0013, 0, 0},
		'{OpUfiRd, 32'h0000_7fa5, 0, 0}, '{OpUfiRd, 32'hfff8_0021, 0, 0},
		'{OpDrain, 0, 0, 0}, '{OpCounts, 0, 0, 0},
		// Burst of strobes past the queue depth
		'{OpUfiWr, 32'h40, 0, 0}, '{OpUfiWr, 32'h41, 0, 0}, '{OpUfiWr, 32'h42, 0, 0},
		'{OpUfiWr, 32'h43, 0, 0}, '{OpUfiWr, 32'h44, 0, 0}, '{OpUfiWr, 32'h45, 0, 0},
		'{OpUfiRd, 32'h40, 0, 0}, '{OpUfiRd, 32'h41, 0, 0}, '{OpUfiRd, 32'h42, 0, 0},
		'{OpUfiRd, 32'h43, 0, 0}, '{OpUfiRd, 32'h44, 0, 0}, '{OpUfiRd, 32'h45, 0, 0},
		'{OpDrain, 0, 0, 0}, '{OpCounts, 0, 0, 0},
		// Requests parked behind a cleared enable
		'{OpUsiWr, cBase + cCsrCtrl, 0, 0}, '{OpUsiRd, cBase + cCsrCtrl, 0, 0},
		'{OpUfiWr, 32'h80, 0, 0}, '{OpUfiWr, 32'h81, 0, 0},
		'{OpUfiRd, 32'h81, 0, 0}, '{OpUfiRd, 32'h80, 0, 0},
		'{OpStall, 0, 24, 0}, '{OpUsiWr, cBase + cCsrCtrl, 1, 0},
		'{OpDrain, 0, 0, 0}, '{OpCounts, 0, 0, 0},
		// Foreign block and unknown offset
		'{OpFgnWr, cFgn + cCsrCtrl, 0, 0}, '{OpFgnRd, cFgn + cCsrCtrl, 0, 0},
		'{OpUsiRd, cBase + cCsrCtrl, 0, 1}, '{OpFgnRd, cBase + 32'h14, 0, 0},
		'{OpUsiRd, cBase + cCsrWrCnt, 0, 12}
	};

	repeat (cResetCycles) @(posedge iSysClk);
	@(negedge iSysClk);
	rstN = 1'b1;
	@(negedge iSysClk);
	checkEq(memCE, 1'b1, "memCE idle after reset");
	checkEq(memOE, 1'b1, "memOE idle after reset");
	checkEq(memWE, 1'b1, "memWE idle after reset");
	checkEq(ufiRdy, 1'b1, "ufiRdy after reset");
	checkEq(ufiRdEd, 1'b0, "ufiRdEd after reset");

	for (int i = 0; i < cStimLen; i++)
	begin
		case (stim[i].op)
			OpUfiWr:  ufiIssue(1'b0, stim[i].adrs);
			OpUfiRd:  ufiIssue(1'b1, stim[i].adrs);
			OpUsiWr:  usiWrite(stim[i].adrs, stim[i].data);
			OpFgnWr:  usiWrite(stim[i].adrs, stim[i].data);
			OpUsiRd:
			begin
				usiRead(stim[i].adrs, rdVal, 1'b1);
				checkEq(rdVal, stim[i].expected, "Usi register read");
			end
			OpFgnRd:  usiRead(stim[i].adrs, rdVal, 1'b0);	// Must stay silent
			OpDrain:  drainQueues();
			OpCounts: checkCounts();
			default:						// OpStall with the pins at rest
			begin
				repeat (stim[i].data)
				begin
					@(negedge iSysClk);
					checkEq(memCE, 1'b1, "memCE held while disabled");
					checkEq(ufiRdEd, 1'b0, "no read return while disabled");
				end
			end
		endcase
	end

	$display("Simulation finished: PASS");
	$finish;
end

endmodule

// File: verilog.f
ramPkg.sv
ramStatIf.sv
ramFifo.sv
ramPinSeq.sv
ramUnit.sv
ramCsr.sv
ramBlock.sv
sramModel.sv
tbRamBlock.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tbRamBlock
FILELIST  := verilog.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing -Wall
BUILDDIR  := obj_dir
PASSMSG   := Simulation finished: PASS

.PHONY: all run lint clean

all: run

$(BUILDDIR)/V$(TOP): $(FILELIST) $(wildcard *.sv)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR)

run: $(BUILDDIR)/V$(TOP)
	@out="$$(./$(BUILDDIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR)
